//--- project.f
+incdir+include
verilog/vec_pkg.sv
verilog/vec_lane_if.sv
verilog/vec_csr.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_top.sv
testbench/tb_vec_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_vec_top -f project.f -o sim_vec_top

out=$(./obj_dir/sim_vec_top)
echo "$out"

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1

//--- testbench/tb_vec_top.sv
// One request in flight at a time; the model writes only elements below vl and keeps tail bytes
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module tb_vec_top
  import vec_pkg::*;
();

  localparam int ClkPeriod   = 20;
  localparam int CyclesPerOp = 30;
  // Operations issued by tests 1 to 6
  localparam int NumOps      = 8 + 12 + 56 + 71 + 4 + 200;

  logic    clk;
  logic    rst;
  logic    acc_req;
  vec_op_e acc_op;
  vreg_t   acc_vd;
  vreg_t   acc_vs1;
  vreg_t   acc_vs2;
  slot_t   acc_scalar;
  logic    acc_ack;
  slot_t   acc_result;

  // Reference state
  slot_t   model_regs [`NR_VREGS][`VLMAX16];
  int      model_vl;
  sew_e    model_sew;

  slot_t   exp_result;
  logic    ack_seen = 1'b0;
  int      n_checks = 0;
  int      n_errors = 0;
  int      test_errors = 0;
  int      test_num = 0;

  vec_top u_vec_top (
    .clk_i       (clk       ),
    .rst_i       (rst       ),
    .acc_req_i   (acc_req   ),
    .acc_op_i    (acc_op    ),
    .acc_vd_i    (acc_vd    ),
    .acc_vs1_i   (acc_vs1   ),
    .acc_vs2_i   (acc_vs2   ),
    .acc_scalar_i(acc_scalar),
    .acc_ack_o   (acc_ack   ),
    .acc_result_o(acc_result)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  function automatic slot_t read_element(input int r, input int e);
    slot_t s;
    if (model_sew == SEW8) begin
      s = model_regs[r][e / 2];
      return (e % 2 == 1) ? {8'h00, s[15:8]} : {8'h00, s[7:0]};
    end
    return model_regs[r][e];
  endfunction

  function automatic void write_element(input int r, input int e, input slot_t v);
    if (model_sew == SEW8) begin
      if (e % 2 == 1) model_regs[r][e / 2][15:8] = v[7:0];
      else model_regs[r][e / 2][7:0] = v[7:0];
    end else begin
      model_regs[r][e] = v;
    end
  endfunction

  function automatic slot_t apply_op(input vec_op_e op, input slot_t a, input slot_t b,
                                     input int scalar);
    slot_t r;
    case (op)
      OP_VADD:   r = a + b;
      OP_VSUB:   r = a - b;
      OP_VXOR:   r = a ^ b;
      OP_VSPLAT: r = slot_t'(scalar);
      default:   r = '0;
    endcase
    // Byte elements wrap at 8 bits
    return (model_sew == SEW8) ? (r & 16'h00ff) : r;
  endfunction

  function automatic slot_t ref_exec(input vec_op_e op, input int vd, input int vs1,
                                     input int vs2, input int scalar);
    int vlmax;
    slot_t res;
    res = '0;
    case (op)
      OP_SETVL16, OP_SETVL8: begin
        model_sew = (op == OP_SETVL8) ? SEW8 : SEW16;
        vlmax     = (op == OP_SETVL8) ? `VLMAX8 : `VLMAX16;
        model_vl  = (scalar > vlmax) ? vlmax : scalar;
        res       = slot_t'(model_vl);
      end
      OP_VEXTRACT: begin
        vlmax = (model_sew == SEW8) ? `VLMAX8 : `VLMAX16;
        if (scalar < vlmax) res = read_element(vs1, scalar);
      end
      default: begin
        for (int e = 0; e < model_vl; e++) begin
          write_element(vd, e, apply_op(op, read_element(vs1, e), read_element(vs2, e), scalar));
        end
      end
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Result compare on each rising ack
  always @(posedge clk) begin
    if (acc_ack && !ack_seen) begin
      n_checks++;
      if (acc_result !== exp_result) begin
        $display("mismatch at %0t ns: acc_result_o expected 0x%h actual 0x%h",
                 $time, exp_result, acc_result);
        n_errors++;
      end
    end
    ack_seen <= acc_ack;
  end

  // Full four-phase transfer with req held for hold extra cycles after ack
  task automatic do_op(input vec_op_e op, input int vd, input int vs1, input int vs2,
                       input int scalar, input int hold);
    int cnt;
    exp_result = ref_exec(op, vd, vs1, vs2, scalar);
    @(posedge clk);
    acc_req    <= 1'b1;
    acc_op     <= op;
    acc_vd     <= vreg_t'(vd);
    acc_vs1    <= vreg_t'(vs1);
    acc_vs2    <= vreg_t'(vs2);
    acc_scalar <= slot_t'(scalar);
    do @(posedge clk); while (!acc_ack);
    repeat (hold) begin
      @(posedge clk);
      if (!acc_ack) begin
        $display("at %0t ns ack fell while req was still high", $time);
        n_errors++;
      end
      if (acc_result !== exp_result) begin
        $display("mismatch at %0t ns: acc_result_o expected 0x%h actual 0x%h",
                 $time, exp_result, acc_result);
        n_errors++;
      end
    end
    acc_req <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (acc_ack && cnt < 4);
    if (acc_ack) begin
      $display("at %0t ns ack stayed high after req was dropped", $time);
      n_errors++;
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s: %s, %0d failing checks", test_num, name,
             (n_errors == test_errors) ? "PASS" : "FAIL", n_errors - test_errors);
    test_errors = n_errors;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  initial begin
    int seed_val;
    int odd_vl;
    int sel;
    vec_op_e rop;
    seed_val   = $urandom(44472);
    rst        = 1'b1;
    acc_req    = 1'b0;
    acc_op     = OP_SETVL16;
    acc_vd     = '0;
    acc_vs1    = '0;
    acc_vs2    = '0;
    acc_scalar = '0;
    exp_result = '0;
    model_vl   = 0;
    model_sew  = SEW16;
    for (int r = 0; r < `NR_VREGS; r++) begin
      for (int s = 0; s < `VLMAX16; s++) model_regs[r][s] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    do_op(OP_VEXTRACT, 0, 0, 0, 0, 0);
    do_op(OP_VEXTRACT, 0, 3, 0, 5, 0);
    do_op(OP_VEXTRACT, 0, 7, 0, 15, 0);
    // Nonzero v2 so that any write under vl 0 would show up in v1
    do_op(OP_SETVL16, 0, 0, 0, 16, 0);
    do_op(OP_VSPLAT, 2, 0, 0, 16'h1234, 0);
    do_op(OP_SETVL16, 0, 0, 0, 0, 0);
    do_op(OP_VADD, 1, 2, 2, 0, 0);
    do_op(OP_VEXTRACT, 0, 1, 0, 0, 0);
    report_test("reset_state");

    for (int i = 0; i < 12; i++) begin
      rop = ($urandom_range(0, 1) == 1) ? OP_SETVL8 : OP_SETVL16;
      do_op(rop, 0, 0, 0, $urandom_range(0, 63), 0);
    end
    report_test("setvl_clamp");

    // Old contents of v3 must survive in the tail
    do_op(OP_SETVL16, 0, 0, 0, 16, 0);
    do_op(OP_VSPLAT, 3, 0, 0, 16'ha5a5, 0);
    do_op(OP_SETVL16, 0, 0, 0, 11, 0);
    do_op(OP_VSPLAT, 1, 0, 0, $urandom_range(0, 65535), 0);
    do_op(OP_VSPLAT, 2, 0, 0, $urandom_range(0, 65535), 0);
    do_op(OP_VADD, 3, 1, 2, 0, 0);
    do_op(OP_VSUB, 4, 1, 2, 0, 0);
    do_op(OP_VXOR, 5, 3, 2, 0, 0);
    for (int r = 3; r < 6; r++) begin
      for (int i = 0; i < 16; i++) do_op(OP_VEXTRACT, 0, r, 0, i, 0);
    end
    report_test("elem16_ops");

    // Odd vl leaves the high byte of the last slot untouched
    odd_vl = 2 * $urandom_range(0, 15) + 1;
    do_op(OP_SETVL8, 0, 0, 0, 32, 0);
    do_op(OP_VSPLAT, 6, 0, 0, 16'h005a, 0);
    do_op(OP_SETVL8, 0, 0, 0, odd_vl, 0);
    do_op(OP_VSPLAT, 1, 0, 0, 16'h00f0, 0);
    do_op(OP_VSPLAT, 2, 0, 0, 16'h0030, 0);
    do_op(OP_VADD, 6, 1, 2, 0, 0);
    do_op(OP_VSUB, 7, 2, 1, 0, 0);
    for (int r = 6; r < 8; r++) begin
      for (int i = 0; i < 32; i++) do_op(OP_VEXTRACT, 0, r, 0, i, 0);
    end
    report_test("elem8_ops");

    do_op(OP_SETVL16, 0, 0, 0, $urandom_range(0, 63), $urandom_range(1, 8));
    do_op(OP_VEXTRACT, 0, 3, 0, $urandom_range(0, 15), $urandom_range(1, 8));
    do_op(OP_VADD, 0, 3, 4, 0, $urandom_range(1, 8));
    do_op(OP_VEXTRACT, 0, 0, 0, $urandom_range(0, 15), $urandom_range(1, 8));
    report_test("handshake_hold");

    for (int i = 0; i < 200; i++) begin
      sel = $urandom_range(0, 9);
      case (sel)
        0: do_op(OP_SETVL16, 0, 0, 0, $urandom_range(0, 40), 0);
        1: do_op(OP_SETVL8, 0, 0, 0, $urandom_range(0, 40), 0);
        2, 3, 4: begin
          rop = (sel == 2) ? OP_VADD : (sel == 3) ? OP_VSUB : OP_VXOR;
          do_op(rop, $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7), 0, 0);
        end
        5: do_op(OP_VSPLAT, $urandom_range(0, 7), 0, 0, $urandom_range(0, 65535), 0);
        default: do_op(OP_VEXTRACT, 0, $urandom_range(0, 7), 0, $urandom_range(0, 35), 0);
      endcase
    end
    report_test("random_mix");

    $display("checks %0d, failures %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NumOps * CyclesPerOp * ClkPeriod);
    $display("timeout: the run did not complete within the expected time");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/vec_top.sv
// Single outstanding request; SETVL acks two cycles after req is seen, vector ops take longer
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module vec_top
  import vec_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    acc_req_i,
  input  vec_op_e acc_op_i,
  input  vreg_t   acc_vd_i,
  input  vreg_t   acc_vs1_i,
  input  vreg_t   acc_vs2_i,
  input  slot_t   acc_scalar_i,
  output logic    acc_ack_o,
  output slot_t   acc_result_o
);

  logic    cfg_we;
  slot_t   cfg_avl;
  sew_e    cfg_sew;
  vl_t     vl;
  sew_e    sew;
  logic    seq_start;
  vec_op_e seq_op;
  vreg_t   seq_vd;
  vreg_t   seq_vs1;
  vreg_t   seq_vs2;
  slot_t   seq_scalar;
  logic    seq_done;
  slot_t   seq_result;

  vec_lane_if u_lane_if ();

  vec_csr u_csr (
    .clk_i    (clk_i  ),
    .rst_i    (rst_i  ),
    .cfg_we_i (cfg_we ),
    .cfg_avl_i(cfg_avl),
    .cfg_sew_i(cfg_sew),
    .vl_o     (vl     ),
    .sew_o    (sew    )
  );

  vec_dispatcher u_dispatcher (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .acc_req_i   (acc_req_i   ),
    .acc_op_i    (acc_op_i    ),
    .acc_vd_i    (acc_vd_i    ),
    .acc_vs1_i   (acc_vs1_i   ),
    .acc_vs2_i   (acc_vs2_i   ),
    .acc_scalar_i(acc_scalar_i),
    .acc_ack_o   (acc_ack_o   ),
    .acc_result_o(acc_result_o),
    .cfg_we_o    (cfg_we      ),
    .cfg_avl_o   (cfg_avl     ),
    .cfg_sew_o   (cfg_sew     ),
    .vl_i        (vl          ),
    .seq_start_o (seq_start   ),
    .seq_op_o    (seq_op      ),
    .seq_vd_o    (seq_vd      ),
    .seq_vs1_o   (seq_vs1     ),
    .seq_vs2_o   (seq_vs2     ),
    .seq_scalar_o(seq_scalar  ),
    .seq_done_i  (seq_done    ),
    .seq_result_i(seq_result  )
  );

  vec_sequencer u_sequencer (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .start_i (seq_start ),
    .op_i    (seq_op    ),
    .vd_i    (seq_vd    ),
    .vs1_i   (seq_vs1   ),
    .vs2_i   (seq_vs2   ),
    .scalar_i(seq_scalar),
    .vl_i    (vl        ),
    .sew_i   (sew       ),
    .done_o  (seq_done  ),
    .result_o(seq_result),
    .lanes   (u_lane_if.seq)
  );

  // One register file slice and ALU per lane
  for (genvar i = 0; i < `NR_LANES; i++) begin : gen_lanes
    vec_lane #(
      .LaneId(i)
    ) u_lane (
      .clk_i(clk_i         ),
      .rst_i(rst_i         ),
      .bus  (u_lane_if.lane)
    );
  end

endmodule

`default_nettype wire

//--- verilog/vec_lane.sv
// LaneId must be below NR_LANES; slot index is row * NR_LANES + LaneId, byte 0 is the low byte
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module vec_lane
  import vec_pkg::*;
#(
  parameter int LaneId = 0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  vec_lane_if.lane bus
);

  localparam int NrBytes = `SLOT_WIDTH / 8;

  slot_t      regs [`NR_VREGS][`NR_ROWS];
  slot_t      op_a;
  slot_t      op_b;
  slot_t      full_res;
  slot_t      byte_res;
  slot_t      alu_res;
  strb_t      strb;
  logic [6:0] slot_idx;
  logic       write_op;
  // Write stage
  logic       wr_valid_q;
  vreg_t      wr_vd_q;
  row_t       wr_row_q;
  slot_t      wr_data_q;
  strb_t      wr_strb_q;
  slot_t      rdata_q;

  assign op_a     = regs[bus.vs1][bus.row];
  assign op_b     = regs[bus.vs2][bus.row];
  assign slot_idx = 7'(bus.row) * 7'(`NR_LANES) + 7'(LaneId);
  assign write_op = bus.op inside {OP_VADD, OP_VSUB, OP_VXOR, OP_VSPLAT};

  // Tail bytes at or above vl stay untouched
  always_comb begin
    for (int b = 0; b < NrBytes; b++) begin
      if (bus.sew == SEW8) strb[b] = (int'(slot_idx) * NrBytes + b) < int'(bus.vl);
      else strb[b] = slot_idx < 7'(bus.vl);
    end
  end

  //////////////////////////////////////////////////
  // ALU with no carry between bytes in 8-bit mode
  always_comb begin
    case (bus.op)
      OP_VADD:   full_res = op_a + op_b;
      OP_VSUB:   full_res = op_a - op_b;
      OP_VXOR:   full_res = op_a ^ op_b;
      OP_VSPLAT: full_res = bus.scalar;
      default:   full_res = '0;
    endcase
    for (int b = 0; b < NrBytes; b++) begin
      case (bus.op)
        OP_VADD:   byte_res[8*b +: 8] = op_a[8*b +: 8] + op_b[8*b +: 8];
        OP_VSUB:   byte_res[8*b +: 8] = op_a[8*b +: 8] - op_b[8*b +: 8];
        OP_VXOR:   byte_res[8*b +: 8] = op_a[8*b +: 8] ^ op_b[8*b +: 8];
        OP_VSPLAT: byte_res[8*b +: 8] = bus.scalar[7:0];
        default:   byte_res[8*b +: 8] = 8'h00;
      endcase
    end
    alu_res = (bus.sew == SEW8) ? byte_res : full_res;
  end

  always_ff @(posedge clk_i) begin
    if (bus.valid) begin
      wr_vd_q   <= bus.vd;
      wr_row_q  <= bus.row;
      wr_data_q <= alu_res;
      wr_strb_q <= strb;
      rdata_q   <= op_a;
    end
  end

  // Register file slice written one cycle after issue
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_valid_q <= 1'b0;
      for (int v = 0; v < `NR_VREGS; v++) begin
        for (int r = 0; r < `NR_ROWS; r++) begin
          regs[v][r] <= '0;
        end
      end
    end else begin
      wr_valid_q <= bus.valid && write_op;
      if (wr_valid_q) begin
        for (int b = 0; b < NrBytes; b++) begin
          if (wr_strb_q[b]) regs[wr_vd_q][wr_row_q][8*b +: 8] <= wr_data_q[8*b +: 8];
        end
      end
    end
  end

  assign bus.rdata[LaneId] = rdata_q;

endmodule

`default_nettype wire

//--- verilog/vec_sequencer.sv
// Operands must stay stable from start to done; extract indices at or above VLMAX return zero
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module vec_sequencer
  import vec_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  vec_op_e     op_i,
  input  vreg_t       vd_i,
  input  vreg_t       vs1_i,
  input  vreg_t       vs2_i,
  input  slot_t       scalar_i,
  input  vl_t         vl_i,
  input  sew_e        sew_i,
  output logic        done_o,
  output slot_t       result_o,
  vec_lane_if.seq     lanes
);

  localparam int LaneW    = $clog2(`NR_LANES);
  localparam int SlotIdxW = $clog2(`VLMAX16);

  seq_state_e            state_q;
  row_t                  row_q;
  logic                  is_extract;
  logic [6:0]            slot_cnt;
  logic [6:0]            row_cnt;
  logic                  last_row;
  logic [SlotIdxW-1:0]   ext_slot;
  logic [LaneW-1:0]      ext_lane;
  row_t                  ext_row;
  logic                  ext_hi;
  logic                  in_range;
  slot_t                 ext_data;
  slot_t                 ext_val;

  assign is_extract = (op_i == OP_VEXTRACT);

  // Rows touched by vl at the current width
  assign slot_cnt = (sew_i == SEW8) ? ((7'(vl_i) + 7'd1) >> 1) : 7'(vl_i);
  assign row_cnt  = (slot_cnt + 7'(`NR_LANES - 1)) >> LaneW;
  assign last_row = (7'(row_q) + 7'd1) == row_cnt;

  //////////////////////////////////////////////////
  // Extract addressing
  assign in_range = (sew_i == SEW8) ? (scalar_i < `VLMAX8) : (scalar_i < `VLMAX16);
  assign ext_slot = (sew_i == SEW8) ? scalar_i[SlotIdxW:1] : scalar_i[SlotIdxW-1:0];
  assign ext_lane = ext_slot[LaneW-1:0];
  assign ext_row  = row_t'(ext_slot >> LaneW);
  assign ext_hi   = (sew_i == SEW8) && scalar_i[0];

  always_comb begin
    ext_data = lanes.rdata[ext_lane];
    if (sew_i == SEW8) ext_val = ext_hi ? {8'h00, ext_data[15:8]} : {8'h00, ext_data[7:0]};
    else ext_val = ext_data;
  end

  //////////////////////////////////////////////////
  // Issue FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= SEQ_IDLE;
      row_q   <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          row_q <= '0;
          if (start_i) begin
            // Nothing to write when vl covers no rows
            if (!is_extract && (row_cnt == 7'd0)) state_q <= SEQ_DONE;
            else state_q <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          if (is_extract) state_q <= SEQ_DONE;
          else if (last_row) state_q <= SEQ_DRAIN;
          else row_q <= row_q + 1'b1;
        end
        SEQ_DRAIN: state_q <= SEQ_DONE;
        SEQ_DONE:  state_q <= SEQ_IDLE;
        default:   state_q <= SEQ_IDLE;
      endcase
    end
  end

  assign lanes.valid  = (state_q == SEQ_ISSUE);
  assign lanes.op     = op_i;
  assign lanes.vd     = vd_i;
  assign lanes.vs1    = vs1_i;
  assign lanes.vs2    = vs2_i;
  assign lanes.row    = is_extract ? ext_row : row_q;
  assign lanes.scalar = scalar_i;
  assign lanes.vl     = vl_i;
  assign lanes.sew    = sew_i;

  assign done_o   = (state_q == SEQ_DONE);
  assign result_o = (is_extract && in_range) ? ext_val : '0;

endmodule

`default_nettype wire

//--- verilog/vec_dispatcher.sv
// Four-phase core handshake with one instruction at a time; core inputs must hold until ack rises
`timescale 1ns/10ps
`default_nettype none

module vec_dispatcher
  import vec_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  // Core side
  input  logic    acc_req_i,
  input  vec_op_e acc_op_i,
  input  vreg_t   acc_vd_i,
  input  vreg_t   acc_vs1_i,
  input  vreg_t   acc_vs2_i,
  input  slot_t   acc_scalar_i,
  output logic    acc_ack_o,
  output slot_t   acc_result_o,
  // Configuration registers
  output logic    cfg_we_o,
  output slot_t   cfg_avl_o,
  output sew_e    cfg_sew_o,
  input  vl_t     vl_i,
  // Sequencer
  output logic    seq_start_o,
  output vec_op_e seq_op_o,
  output vreg_t   seq_vd_o,
  output vreg_t   seq_vs1_o,
  output vreg_t   seq_vs2_o,
  output slot_t   seq_scalar_o,
  input  logic    seq_done_i,
  input  slot_t   seq_result_i
);

  disp_state_e state_q;
  logic        accept;
  logic        is_setvl;
  logic        start_q;
  vec_op_e     op_q;
  slot_t       result_q;

  assign accept   = (state_q == DISP_IDLE) && acc_req_i;
  assign is_setvl = acc_op_i inside {OP_SETVL16, OP_SETVL8};

  //////////////////////////////////////////////////
  // Handshake FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= DISP_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= accept && !is_setvl;
      case (state_q)
        DISP_IDLE: if (acc_req_i) state_q <= is_setvl ? DISP_CFG : DISP_EXEC;
        DISP_CFG:  state_q <= DISP_ACK;
        DISP_EXEC: if (seq_done_i) state_q <= DISP_ACK;
        DISP_ACK:  if (!acc_req_i) state_q <= DISP_IDLE;
        default:   state_q <= DISP_IDLE;
      endcase
    end
  end

  // Instruction fields held until the response is taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q         <= acc_op_i;
      seq_vd_o     <= acc_vd_i;
      seq_vs1_o    <= acc_vs1_i;
      seq_vs2_o    <= acc_vs2_i;
      seq_scalar_o <= acc_scalar_i;
    end
    if ((state_q == DISP_EXEC) && seq_done_i) result_q <= seq_result_i;
  end

  assign cfg_we_o    = (state_q == DISP_CFG);
  assign cfg_avl_o   = seq_scalar_o;
  assign cfg_sew_o   = (op_q == OP_SETVL8) ? SEW8 : SEW16;
  assign seq_start_o = start_q;
  assign seq_op_o    = op_q;

  // SETVL answers with the freshly written length
  assign acc_ack_o    = (state_q == DISP_ACK);
  assign acc_result_o = (op_q inside {OP_SETVL16, OP_SETVL8}) ? slot_t'(vl_i) : result_q;

endmodule

`default_nettype wire

//--- verilog/vec_csr.sv
// Lengths above VLMAX of the requested width are clamped; outputs change one cycle after the write
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

module vec_csr
  import vec_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  cfg_we_i,
  input  slot_t cfg_avl_i,
  input  sew_e  cfg_sew_i,
  output vl_t   vl_o,
  output sew_e  sew_o
);

  slot_t vlmax;
  vl_t   vl_d;

  // Clamp against the limit of the new width
  always_comb begin
    vlmax = (cfg_sew_i == SEW8) ? slot_t'(`VLMAX8) : slot_t'(`VLMAX16);
    vl_d  = (cfg_avl_i > vlmax) ? vl_t'(vlmax) : vl_t'(cfg_avl_i);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vl_o  <= '0;
      sew_o <= SEW16;
    end else if (cfg_we_i) begin
      vl_o  <= vl_d;
      sew_o <= cfg_sew_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vec_lane_if.sv
// One issue per cycle from the sequencer; each lane returns its vs1 read one cycle after valid
`timescale 1ns/10ps
`default_nettype none

`include "vec_macros.svh"

interface vec_lane_if
  import vec_pkg::*;
();

  logic    valid;
  vec_op_e op;
  vreg_t   vd;
  vreg_t   vs1;
  vreg_t   vs2;
  row_t    row;
  slot_t   scalar;
  vl_t     vl;
  sew_e    sew;
  // One entry per lane
  slot_t   rdata [`NR_LANES];

  modport seq (output valid, op, vd, vs1, vs2, row, scalar, vl, sew, input rdata);

  modport lane (input valid, op, vd, vs1, vs2, row, scalar, vl, sew, output rdata);

endinterface

`default_nettype wire

//--- verilog/vec_pkg.sv
// Types sized from the shared macros; vl_t covers 0 up to and including VLMAX8
`default_nettype none

`include "vec_macros.svh"

package vec_pkg;

  typedef enum logic [2:0] {
    OP_SETVL16  = 3'd0,
    OP_SETVL8   = 3'd1,
    OP_VADD     = 3'd2,
    OP_VSUB     = 3'd3,
    OP_VXOR     = 3'd4,
    OP_VSPLAT   = 3'd5,
    OP_VEXTRACT = 3'd6
  } vec_op_e;

  typedef enum logic {
    SEW16 = 1'b0,
    SEW8  = 1'b1
  } sew_e;

  typedef logic [$clog2(`NR_VREGS)-1:0]  vreg_t;
  typedef logic [`SLOT_WIDTH-1:0]        slot_t;
  typedef logic [`SLOT_WIDTH/8-1:0]      strb_t;
  typedef logic [$clog2(`NR_ROWS)-1:0]   row_t;
  typedef logic [$clog2(`VLMAX8+1)-1:0]  vl_t;

  // Handshake FSM
  typedef enum logic [1:0] {DISP_IDLE, DISP_CFG, DISP_EXEC, DISP_ACK} disp_state_e;

  // Row issue FSM
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_DRAIN, SEQ_DONE} seq_state_e;

endpackage

`default_nettype wire

//--- include/vec_macros.svh
// Lane and row counts must be powers of two; one slot holds one 16-bit or two 8-bit elements
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Number of parallel lanes
`define NR_LANES 4

// Slots per lane in each vector register
`define NR_ROWS 4

// Architectural vector registers
`define NR_VREGS 8

// Bits per slot
`define SLOT_WIDTH 16

// Maximum vector length per element width
`define VLMAX16 (`NR_LANES * `NR_ROWS)
`define VLMAX8 (2 * `VLMAX16)

`endif
